/* hdl/icachePkg.sv */
/*
 * Instruction cache shared types
 * Line geometry, fetch address layout and Wishbone bundles
 */
package icachePkg;

    // Geometry of the cache
    localparam int NUM_SETS    = 8;
    localparam int LINE_WORDS  = 4;
    localparam int SET_BITS    = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int TAG_BITS    = 30 - SET_BITS - OFFSET_BITS;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [SET_BITS-1:0]    setIdx;
        logic [OFFSET_BITS-1:0] offset;
        logic [1:0]             byteOff;
    } addrFieldsT;

    // Same 32-bit word seen as a raw address or as cache fields
    typedef union packed {
        logic [31:0] raw;
        addrFieldsT  fields;
    } fetchAddrT;

    typedef struct packed {
        logic      valid;
        fetchAddrT addr;
    } fetchReqT;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
    } wbReqT;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wbRspT;

    typedef enum logic [1:0] {LOOKUP, REFILL, FLUSH} ctrlStateT;

endpackage

/* hdl/refillCounter.sv */
/*
 * Refill word counter
 * Tracks the word offset of the line being fetched from memory
 */
module refillCounter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             clear,
    input  logic                             advance,
    output logic [icachePkg::OFFSET_BITS-1:0] offset,
    output logic                             lastWord
);
    import icachePkg::*;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            offset <= '0;
        end else if (advance) begin
            offset <= offset + 1'b1;
        end
    end

    assign lastWord = (offset == OFFSET_BITS'(LINE_WORDS - 1));

    // The controller must close the refill on the last word instead of letting it wrap
    lastWordClears: assert property (
        @(posedge clk) disable iff (rst)
        advance && lastWord |-> clear
    );

endmodule

/* hdl/icacheController.sv */
/*
 * Instruction cache controller
 * Sequences lookup, line refill over Wishbone classic and flush
 */
module icacheController (
    input  logic clk,
    input  logic rst,
    input  logic lookupValid,
    input  logic hit,
    input  logic invalidate,
    input  logic ack,
    input  logic lastWord,
    output logic stall,
    output logic wbCyc,
    output logic wbStb,
    output logic fillWrite,
    output logic fillDone,
    output logic counterClear,
    output logic counterAdvance,
    output logic flush
);
    import icachePkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      strobeGap;
    logic      pendingInv;

    // One idle cycle after every ack keeps classic cycles apart
    assign wbCyc          = (state == REFILL) && !strobeGap;
    assign wbStb          = wbCyc;
    assign fillWrite      = wbStb && ack;
    assign fillDone       = fillWrite && lastWord;
    assign counterAdvance = fillWrite;
    assign counterClear   = (state != REFILL) || fillDone;
    assign flush          = (state == FLUSH);

    always_comb begin
        nextState = state;
        stall     = 1'b1;
        case (state)
            LOOKUP: begin
                stall = lookupValid && !hit;
                if (invalidate) begin
                    nextState = FLUSH;
                end else if (lookupValid && !hit) begin
                    nextState = REFILL;
                end
            end
            REFILL: begin
                if (fillDone) begin
                    nextState = (pendingInv || invalidate) ? FLUSH : LOOKUP;
                end
            end
            FLUSH: nextState = LOOKUP;
            default: nextState = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= LOOKUP;
            strobeGap  <= 1'b0;
            pendingInv <= 1'b0;
        end else begin
            state     <= nextState;
            strobeGap <= fillWrite;
            // Invalidate seen mid-refill waits for the line to finish
            pendingInv <= (state == REFILL) ? (pendingInv || invalidate) : 1'b0;
        end
    end

    stbHeldUntilAck: assert property (
        @(posedge clk) disable iff (rst)
        wbStb && !ack |=> wbStb && wbCyc
    );

    ackThenGap: assert property (
        @(posedge clk) disable iff (rst)
        fillWrite |=> !wbCyc
    );

endmodule

/* hdl/icacheWayArray.sv */
/*
 * Two-way tag, valid, data and LRU storage
 * Combinational lookup with victim selection and line fill
 */
module icacheWayArray (
    input  logic                             clk,
    input  logic                             rst,
    input  icachePkg::fetchAddrT             lookupAddr,
    input  logic                             fillWrite,
    input  logic                             fillDone,
    input  logic [icachePkg::OFFSET_BITS-1:0] fillOffset,
    input  logic [31:0]                      fillData,
    input  logic                             flush,
    output logic                             hit,
    output logic [31:0]                      hitWord
);
    import icachePkg::*;

    logic [TAG_BITS-1:0]    tagMem [2][NUM_SETS];
    logic [31:0]            dataMem [2][NUM_SETS][LINE_WORDS];
    logic [NUM_SETS-1:0]    validBits [2];
    logic [NUM_SETS-1:0]    lruBits;

    logic [SET_BITS-1:0]    setIdx;
    logic [OFFSET_BITS-1:0] wordIdx;
    logic [1:0]             wayHit;
    logic                   victimNow;
    logic                   victimWay;
    logic                   fillActive;

    assign setIdx  = lookupAddr.fields.setIdx;
    assign wordIdx = lookupAddr.fields.offset;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validBits[w][setIdx] && (tagMem[w][setIdx] == lookupAddr.fields.tag);
        end
    end

    assign hit     = |wayHit;
    assign hitWord = wayHit[1] ? dataMem[1][setIdx][wordIdx] : dataMem[0][setIdx][wordIdx];

    // Empty way first, LRU way otherwise
    assign victimNow = !validBits[0][setIdx] ? 1'b0 :
                       !validBits[1][setIdx] ? 1'b1 : lruBits[setIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            victimWay  <= 1'b0;
            fillActive <= 1'b0;
        end else begin
            if (!fillActive && !fillWrite && !hit) begin
                victimWay <= victimNow;
            end
            if (fillDone) begin
                fillActive <= 1'b0;
            end else if (fillWrite) begin
                fillActive <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            validBits[0] <= '0;
            validBits[1] <= '0;
            lruBits      <= '0;
        end else if (fillDone) begin
            validBits[victimWay][setIdx] <= 1'b1;
            lruBits[setIdx]              <= ~victimWay;
        end else if (hit) begin
            // LRU now names the way that did not hit
            lruBits[setIdx] <= wayHit[0];
        end
    end

    always_ff @(posedge clk) begin
        if (fillWrite) begin
            dataMem[victimWay][setIdx][fillOffset] <= fillData;
        end
        if (fillDone) begin
            tagMem[victimWay][setIdx] <= lookupAddr.fields.tag;
        end
    end

    noDuplicateTag: assert property (
        @(posedge clk) disable iff (rst)
        validBits[0][setIdx] && validBits[1][setIdx] |-> tagMem[0][setIdx] != tagMem[1][setIdx]
    );

endmodule

/* hdl/instrCache.sv */
/*
 * Two-way set-associative instruction cache
 * Hits answer in the same cycle, misses refill a line over Wishbone classic
 */
module instrCache (
    input  logic                clk,
    input  logic                rst,
    input  icachePkg::fetchReqT fetchReq,
    input  logic                invalidate,
    output logic [31:0]         instr,
    output logic                stall,
    output icachePkg::wbReqT    wbReq,
    input  icachePkg::wbRspT    wbRsp
);
    import icachePkg::*;

    fetchAddrT              lookupAddr;
    fetchAddrT              refillAddr;
    logic [OFFSET_BITS-1:0] fillOffset;
    logic                   hit;
    logic                   lastWord;
    logic                   wbCyc;
    logic                   wbStb;
    logic                   fillWrite;
    logic                   fillDone;
    logic                   counterClear;
    logic                   counterAdvance;
    logic                   flush;

    assign lookupAddr.raw = fetchReq.addr.raw;

    // Line base from the fetch address, word from the refill counter
    always_comb begin
        refillAddr.fields.tag     = lookupAddr.fields.tag;
        refillAddr.fields.setIdx  = lookupAddr.fields.setIdx;
        refillAddr.fields.offset  = fillOffset;
        refillAddr.fields.byteOff = 2'b00;
    end

    always_comb begin
        wbReq.cyc = wbCyc;
        wbReq.stb = wbStb;
        wbReq.we  = 1'b0;
        wbReq.adr = refillAddr.raw;
        wbReq.sel = 4'hf;
    end

    refillCounter u_counter (
        .clk     (clk           ),
        .rst     (rst           ),
        .clear   (counterClear  ),
        .advance (counterAdvance),
        .offset  (fillOffset    ),
        .lastWord(lastWord      )
    );

    icacheController u_ctrl (
        .clk           (clk           ),
        .rst           (rst           ),
        .lookupValid   (fetchReq.valid),
        .hit           (hit           ),
        .invalidate    (invalidate    ),
        .ack           (wbRsp.ack     ),
        .lastWord      (lastWord      ),
        .stall         (stall         ),
        .wbCyc         (wbCyc         ),
        .wbStb         (wbStb         ),
        .fillWrite     (fillWrite     ),
        .fillDone      (fillDone      ),
        .counterClear  (counterClear  ),
        .counterAdvance(counterAdvance),
        .flush         (flush         )
    );

    icacheWayArray u_ways (
        .clk       (clk       ),
        .rst       (rst       ),
        .lookupAddr(lookupAddr),
        .fillWrite (fillWrite ),
        .fillDone  (fillDone  ),
        .fillOffset(fillOffset),
        .fillData  (wbRsp.dat ),
        .flush     (flush     ),
        .hit       (hit       ),
        .hitWord   (instr     )
    );

endmodule

/* testbench/tbMemModel.sv */
/*
 * Wishbone classic slave memory for the cache testbench
 * Acks after random wait states with data scrambled from the address
 */
module tbMemModel (
    input  logic             clk,
    input  logic             rst,
    input  icachePkg::wbReqT wbReq,
    output icachePkg::wbRspT wbRsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import icachePkg::*;

    integer      seed = 38;
    logic [1:0]  waitLeft;
    logic [31:0] addrLog [$];

    // Memory contents are a fixed scramble of the word address
    function automatic logic [31:0] wordAt(input logic [31:0] adr);
        return ({adr[7:0], adr[31:8]} ^ 32'h5a3c96e1) + adr;
    endfunction

    initial begin
        wbRsp = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            wbRsp.ack <= 1'b0;
            wbRsp.dat <= '0;
            waitLeft  <= 2'd0;
        end else if (wbRsp.ack) begin
            // Master takes the word at this edge and ends the cycle
            addrLog.push_back(wbReq.adr);
            wbRsp.ack <= 1'b0;
            waitLeft  <= 2'($random(seed));
        end else if (wbReq.cyc && wbReq.stb) begin
            if (waitLeft == 2'd0) begin
                wbRsp.ack <= 1'b1;
                wbRsp.dat <= wordAt(wbReq.adr);
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

endmodule

/* testbench/tbInstrCache.sv */
/*
 * Instruction cache testbench
 * Random fetches checked against a reference directory model
 */
module tbInstrCache;
    timeunit 1ns;
    timeprecision 1ps;
    import icachePkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int RANDOM_RUNS = 400;

    logic                clk;
    logic                rst;
    fetchReqT            fetchReq;
    logic                invalidate;
    logic [31:0]         instr;
    logic                stall;
    wbReqT               wbReq;
    wbRspT               wbRsp;

    integer              seed = 38;
    logic [TAG_BITS-1:0] tagPool [4];
    // Reference copy of the cache directory
    logic [TAG_BITS-1:0] modelTag [2][NUM_SETS];
    logic                modelValid [2][NUM_SETS];
    logic                modelLru [NUM_SETS];
    logic                holdPending = 1'b0;
    logic [31:0]         heldAdr;

    instrCache u_dut (
        .clk       (clk       ),
        .rst       (rst       ),
        .fetchReq  (fetchReq  ),
        .invalidate(invalidate),
        .instr     (instr     ),
        .stall     (stall     ),
        .wbReq     (wbReq     ),
        .wbRsp     (wbRsp     )
    );

    tbMemModel u_mem (
        .clk  (clk  ),
        .rst  (rst  ),
        .wbReq(wbReq),
        .wbRsp(wbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Same scramble that the memory model applies
    function automatic logic [31:0] expectedInstr(input logic [31:0] adr);
        return ({adr[7:0], adr[31:8]} ^ 32'h5a3c96e1) + adr;
    endfunction

    function automatic logic [31:0] wordAddr(input logic [TAG_BITS-1:0] tag, input int s,
                                             input int off);
        return {tag, SET_BITS'(s), OFFSET_BITS'(off), 2'b00};
    endfunction

    function automatic int findWay(input logic [TAG_BITS-1:0] tag,
                                   input logic [SET_BITS-1:0] s);
        int way;
        way = -1;
        if (modelValid[0][s] && modelTag[0][s] == tag) begin
            way = 0;
        end else if (modelValid[1][s] && modelTag[1][s] == tag) begin
            way = 1;
        end
        return way;
    endfunction

    task automatic stopWithFail();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            stopWithFail();
        end
    endtask

    task automatic waitStallLow(input string what);
        int waited;
        waited = 0;
        while (stall) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Timeout: stall stayed high during %s", what);
                stopWithFail();
            end
        end
    endtask

    task automatic clearModel();
        int s;
        for (s = 0; s < NUM_SETS; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
            modelLru[s]      = 1'b0;
        end
    endtask

    task automatic doFetch(input logic [31:0] adr, output logic wasHit);
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] s;
        logic [31:0]         lineBase;
        logic                victim;
        int                  way;
        int                  logStart;
        int                  i;
        tag      = adr[31 -: TAG_BITS];
        s        = adr[2+OFFSET_BITS +: SET_BITS];
        lineBase = {adr[31:2+OFFSET_BITS], (OFFSET_BITS+2)'(0)};
        way      = findWay(tag, s);
        wasHit   = (way >= 0);
        logStart = u_mem.addrLog.size();
        @(posedge clk);
        fetchReq.valid    <= 1'b1;
        fetchReq.addr.raw <= adr;
        @(negedge clk);
        checkValue("stall", 32'(!wasHit), 32'(stall));
        if (wasHit) begin
            // A refill would raise cyc in the next cycle
            @(negedge clk);
            checkValue("wbReq.cyc", 32'(0), 32'(wbReq.cyc));
            modelLru[s] = (way == 0);
        end else begin
            victim = !modelValid[0][s] ? 1'b0 : !modelValid[1][s] ? 1'b1 : modelLru[s];
            waitStallLow("line refill");
            checkValue("refill word count", 32'(LINE_WORDS), 32'(u_mem.addrLog.size() - logStart));
            for (i = 0; i < LINE_WORDS; i++) begin
                checkValue("wbReq.adr", lineBase + 32'(i * 4), u_mem.addrLog[logStart + i]);
            end
            modelTag[victim][s]   = tag;
            modelValid[victim][s] = 1'b1;
            modelLru[s]           = !victim;
        end
        checkValue("instr", expectedInstr(adr), instr);
    endtask

    task automatic doInvalidate();
        @(posedge clk);
        fetchReq.valid <= 1'b0;
        invalidate     <= 1'b1;
        @(posedge clk);
        invalidate <= 1'b0;
        @(negedge clk);
        // FLUSH cycle holds the fetch side off
        checkValue("stall", 32'(1), 32'(stall));
        waitStallLow("flush");
        clearModel();
    endtask

    task automatic checkOutcome(input logic expected, input logic got);
        checkValue("predicted hit", 32'(expected), 32'(got));
    endtask

    // Wishbone classic rules on every cycle
    always @(negedge clk) begin
        if (rst) begin
            holdPending = 1'b0;
        end else begin
            if (wbReq.stb) begin
                checkValue("wbReq.cyc", 32'(1), 32'(wbReq.cyc));
                checkValue("wbReq.we", 32'(0), 32'(wbReq.we));
                checkValue("wbReq.sel", 32'(4'hf), 32'(wbReq.sel));
            end
            if (holdPending) begin
                checkValue("wbReq.stb", 32'(1), 32'(wbReq.stb));
                checkValue("wbReq.adr", heldAdr, wbReq.adr);
            end
            holdPending = wbReq.stb && !wbRsp.ack;
            heldAdr     = wbReq.adr;
        end
    end

    initial begin
        logic        wasHit;
        logic [31:0] r;
        int          n;
        rst        = 1'b1;
        invalidate = 1'b0;
        fetchReq   = '0;
        tagPool[0] = TAG_BITS'(32'h0000_0010);
        tagPool[1] = TAG_BITS'(32'h01ab_cdef);
        tagPool[2] = TAG_BITS'(32'h0155_5555);
        tagPool[3] = TAG_BITS'(32'h00f0_0f0f);
        clearModel();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("wbReq.cyc", 32'(0), 32'(wbReq.cyc));
        checkValue("wbReq.stb", 32'(0), 32'(wbReq.stb));

        // Fill both ways of set 3, then a third tag evicts the LRU one
        doFetch(wordAddr(tagPool[0], 3, 0), wasHit);
        checkOutcome(1'b0, wasHit);
        doFetch(wordAddr(tagPool[1], 3, 1), wasHit);
        checkOutcome(1'b0, wasHit);
        doFetch(wordAddr(tagPool[0], 3, 2), wasHit);
        checkOutcome(1'b1, wasHit);
        doFetch(wordAddr(tagPool[2], 3, 3), wasHit);
        checkOutcome(1'b0, wasHit);
        doFetch(wordAddr(tagPool[0], 3, 1), wasHit);
        checkOutcome(1'b1, wasHit);
        doFetch(wordAddr(tagPool[1], 3, 0), wasHit);
        checkOutcome(1'b0, wasHit);

        // A cached line misses again once invalidated
        doFetch(wordAddr(tagPool[1], 3, 2), wasHit);
        checkOutcome(1'b1, wasHit);
        doInvalidate();
        doFetch(wordAddr(tagPool[1], 3, 2), wasHit);
        checkOutcome(1'b0, wasHit);

        for (n = 0; n < RANDOM_RUNS; n++) begin
            r = $random(seed);
            if (r[9:5] == 5'd0) begin
                doInvalidate();
            end
            doFetch(wordAddr(tagPool[r[1:0]], int'(r[4:2]), int'(r[11:10])), wasHit);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* files.f */
hdl/icachePkg.sv
hdl/refillCounter.sv
hdl/icacheController.sv
hdl/icacheWayArray.sv
hdl/instrCache.sv
testbench/tbMemModel.sv
testbench/tbInstrCache.sv

/* run.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbInstrCache -f files.f -o simInstrCache

# The log decides pass or fail
./obj_dir/simInstrCache > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
